//--- fb_pkg.sv
package fb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // video geometry and memory word layout
    ////////////////////////////////////////////////////////////////////////////
    localparam int PIX_W        = 16;                      // rgb565 pixel
    localparam int WORD_W       = 64;                      // memory bus word
    localparam int PIX_PER_WORD = WORD_W / PIX_W;          // 4 lanes
    localparam int H_PIX        = 32;                      // pixels per line
    localparam int V_LINES      = 8;                       // lines per frame
    localparam int BURST_WORDS  = H_PIX / PIX_PER_WORD;    // one line per burst

    ////////////////////////////////////////////////////////////////////////////
    // address map, two banks back to back
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_W       = 20;                      // byte address
    localparam int LINE_BYTES   = BURST_WORDS * WORD_W / 8;
    localparam int BANK_BYTES   = LINE_BYTES * V_LINES;    // bank 1 base

    localparam int LINE_IDX_W   = $clog2(V_LINES);
    localparam int WORD_IDX_W   = $clog2(BURST_WORDS);
    localparam int LANE_W       = $clog2(PIX_PER_WORD);    // pixel lane select

    // burst master states
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_WADDR = 3'd1;
    localparam logic [2:0] ST_WDATA = 3'd2;
    localparam logic [2:0] ST_RADDR = 3'd3;
    localparam logic [2:0] ST_RDATA = 3'd4;

    // one memory word, seen raw by the bus or as pixel lanes, lane 0 low
    typedef union packed
    {
        logic [WORD_W-1:0]                 raw;
        logic [PIX_PER_WORD-1:0][PIX_W-1:0] pix;
    } pix_word_t;

endpackage

//--- line_writer.sv
`timescale 1ns/1ps
module line_writer
    import fb_pkg::*;
(
    input  logic              ddr_clk,
    input  logic              rst_n,
    input  logic              pix_fsync,
    input  logic              pix_valid,
    input  logic [PIX_W-1:0]  pix_data,
    input  logic              wr_ready,
    input  logic              wr_done,
    input  logic              wr_data_re,
    output logic              wr_req,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [WORD_W-1:0] wr_data,
    output logic              wr_overflow,
    output logic              frame_done,
    output logic              done_bank
);

    logic [WORD_W-1:0]     line_mem [2*BURST_WORDS];   // two line buffers
    logic [LINE_IDX_W-1:0] buf_line [2];               // line number per buffer
    pix_word_t             pack_q;                     // word under assembly
    pix_word_t             pack_nxt;

    logic [LANE_W-1:0]     in_lane, lane_c;
    logic [WORD_IDX_W-1:0] in_word, word_c;
    logic [LINE_IDX_W-1:0] in_line, line_c;
    logic                  in_buf;                     // buffer being filled
    logic [1:0]            buf_full;
    logic                  pix_take, word_end, line_end;

    logic                  out_buf;                    // buffer being sent
    logic [WORD_IDX_W-1:0] out_word;
    logic                  wr_busy;                    // granted, waiting done
    logic                  wr_bank;

    ////////////////////////////////////////////////////////////////////////////
    // pixel packing
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        lane_c   = pix_fsync ? '0 : in_lane;           // fsync restarts raster
        word_c   = pix_fsync ? '0 : in_word;
        line_c   = pix_fsync ? '0 : in_line;
        pack_nxt = pack_q;
        pack_nxt.pix[lane_c] = pix_data;               // drop pixel into lane
    end

    assign pix_take = pix_valid && !(&buf_full);       // no room, pixel lost
    assign word_end = pix_take && (lane_c == LANE_W'(PIX_PER_WORD - 1));
    assign line_end = word_end && (word_c == WORD_IDX_W'(BURST_WORDS - 1));

    always_ff @(posedge ddr_clk)
    begin
        if (pix_take)
            pack_q <= pack_nxt;
        if (word_end)
            line_mem[{in_buf, word_c}] <= pack_nxt.raw;
        if (line_end)
            buf_line[in_buf] <= line_c;                // tag for the address
    end

    ////////////////////////////////////////////////////////////////////////////
    // fill and send bookkeeping
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            in_lane     <= '0;
            in_word     <= '0;
            in_line     <= '0;
            in_buf      <= 1'b0;
            buf_full    <= 2'b00;
            out_buf     <= 1'b0;
            out_word    <= '0;
            wr_busy     <= 1'b0;
            wr_bank     <= 1'b0;
            wr_overflow <= 1'b0;
        end
        else
        begin
            if (pix_valid && (&buf_full))
                wr_overflow <= 1'b1;                   // sticky
            if (pix_take)
            begin
                in_lane <= lane_c + 1'b1;
                in_word <= word_end ? word_c + 1'b1 : word_c;
                in_line <= line_end ? line_c + 1'b1 : line_c;
            end
            if (line_end)
            begin
                buf_full[in_buf] <= 1'b1;              // line ready to send
                in_buf           <= ~in_buf;
            end
            if (wr_ready)
                wr_busy <= 1'b1;
            if (wr_data_re)
                out_word <= out_word + 1'b1;           // next beat
            if (wr_done)
            begin
                wr_busy           <= 1'b0;
                buf_full[out_buf] <= 1'b0;
                out_buf           <= ~out_buf;
                out_word          <= '0;
                if (frame_done)
                    wr_bank <= ~wr_bank;               // next frame, other bank
            end
        end
    end

    assign wr_req     = buf_full[out_buf] && !wr_busy;
    assign wr_data    = line_mem[{out_buf, out_word}];
    assign wr_addr    = ADDR_W'(int'(wr_bank) * BANK_BYTES
                        + int'(buf_line[out_buf]) * LINE_BYTES);
    assign frame_done = wr_done && (buf_line[out_buf] == LINE_IDX_W'(V_LINES - 1));
    assign done_bank  = wr_bank;                       // bank just completed

endmodule

//--- line_reader.sv
`timescale 1ns/1ps
module line_reader
    import fb_pkg::*;
(
    input  logic              ddr_clk,
    input  logic              rst_n,
    input  logic              rd_fsync,
    input  logic              rd_en,
    input  logic              frame_done,
    input  logic              done_bank,
    input  logic              rd_ready,
    input  logic              rd_done,
    input  logic              rd_data_en,
    input  logic [WORD_W-1:0] rd_data,
    output logic              vout_de,
    output logic [PIX_W-1:0]  vout_data,
    output logic              init_done,
    output logic              rd_req,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              rd_underrun
);

    logic [WORD_W-1:0]     line_mem [2*BURST_WORDS];   // prefetch buffers
    pix_word_t             cur_word;
    logic                  last_bank;                  // newest complete frame
    logic                  rd_bank;                    // frame on display
    logic                  active;                     // frame being output
    logic                  flush;                      // drop stale burst
    logic                  rd_busy;
    logic [1:0]            buf_valid;

    logic                  fetch_buf;
    logic [WORD_IDX_W-1:0] fetch_word;
    logic [LINE_IDX_W-1:0] fetch_line;
    logic                  fetch_all;                  // whole frame requested

    logic                  out_buf;
    logic [WORD_IDX_W-1:0] out_word;
    logic [LANE_W-1:0]     out_lane;
    logic [LINE_IDX_W-1:0] out_line;
    logic                  pix_ok;

    always_ff @(posedge ddr_clk)
    begin
        if (rd_data_en)
            line_mem[{fetch_buf, fetch_word}] <= rd_data;
    end

    assign cur_word.raw = line_mem[{out_buf, out_word}];
    assign pix_ok       = active && buf_valid[out_buf];
    assign rd_req       = active && !rd_busy && !fetch_all && !buf_valid[fetch_buf];
    assign rd_addr      = ADDR_W'(int'(rd_bank) * BANK_BYTES + int'(fetch_line) * LINE_BYTES);

    ////////////////////////////////////////////////////////////////////////////
    // prefetch and output
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            init_done   <= 1'b0;
            last_bank   <= 1'b0;
            rd_bank     <= 1'b0;
            active      <= 1'b0;
            flush       <= 1'b0;
            rd_busy     <= 1'b0;
            buf_valid   <= 2'b00;
            fetch_buf   <= 1'b0;
            fetch_word  <= '0;
            fetch_line  <= '0;
            fetch_all   <= 1'b0;
            out_buf     <= 1'b0;
            out_word    <= '0;
            out_lane    <= '0;
            out_line    <= '0;
            vout_de     <= 1'b0;
            vout_data   <= '0;
            rd_underrun <= 1'b0;
        end
        else
        begin
            vout_de <= rd_en;                          // fixed one-cycle latency
            if (frame_done)
            begin
                init_done <= 1'b1;                     // sticky
                last_bank <= done_bank;
            end
            if (rd_ready)
                rd_busy <= 1'b1;
            if (rd_data_en)
                fetch_word <= fetch_word + 1'b1;
            if (rd_done)
            begin
                rd_busy    <= 1'b0;
                fetch_word <= '0;
                flush      <= 1'b0;
                if (!flush)
                begin
                    buf_valid[fetch_buf] <= 1'b1;      // line loaded
                    fetch_buf            <= ~fetch_buf;
                    fetch_line           <= fetch_line + 1'b1;
                    if (fetch_line == LINE_IDX_W'(V_LINES - 1))
                        fetch_all <= 1'b1;
                end
            end
            if (rd_fsync)
            begin
                rd_bank    <= last_bank;               // freeze displayed frame
                active     <= init_done;
                flush      <= rd_busy && !rd_done;     // burst of old frame in flight
                buf_valid  <= 2'b00;
                fetch_buf  <= 1'b0;
                fetch_line <= '0;
                fetch_all  <= 1'b0;
                out_buf    <= 1'b0;
                out_word   <= '0;
                out_lane   <= '0;
                out_line   <= '0;
                vout_data  <= '0;
            end
            else if (rd_en)
            begin
                if (pix_ok)
                begin
                    vout_data <= cur_word.pix[out_lane];
                    out_lane  <= out_lane + 1'b1;
                    if (out_lane == LANE_W'(PIX_PER_WORD - 1))
                    begin
                        out_word <= out_word + 1'b1;
                        if (out_word == WORD_IDX_W'(BURST_WORDS - 1))
                        begin
                            buf_valid[out_buf] <= 1'b0;    // free for refill
                            out_buf            <= ~out_buf;
                            out_line           <= out_line + 1'b1;
                            if (out_line == LINE_IDX_W'(V_LINES - 1))
                                active <= 1'b0;        // frame fully shown
                        end
                    end
                end
                else
                begin
                    vout_data <= '0;
                    if (active)
                        rd_underrun <= 1'b1;           // line not loaded in time
                end
            end
        end
    end

endmodule

//--- burst_master.sv
`timescale 1ns/1ps
module burst_master
    import fb_pkg::*;
(
    input  logic              ddr_clk,
    input  logic              rst_n,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              axi_awready,
    input  logic              axi_wready,
    input  logic              axi_arready,
    input  logic              axi_rvalid,
    input  logic              axi_rlast,
    input  logic [WORD_W-1:0] axi_rdata,
    output logic              wr_ready,
    output logic              wr_done,
    output logic              wr_data_re,
    output logic              rd_ready,
    output logic              rd_done,
    output logic              rd_data_en,
    output logic [WORD_W-1:0] rd_data,
    output logic [ADDR_W-1:0] axi_awaddr,
    output logic [ADDR_W-1:0] axi_araddr,
    output logic              axi_awvalid,
    output logic              axi_wvalid,
    output logic              axi_wlast,
    output logic              axi_arvalid,
    output logic [WORD_W-1:0] axi_wdata
);

    logic [2:0]            state;
    logic [WORD_IDX_W-1:0] beat;                       // write beats taken
    logic [ADDR_W-1:0]     cmd_addr;                   // address of granted burst
    logic                  last_wr;                    // write served last
    logic                  grant_wr;
    logic                  grant_rd;

    ////////////////////////////////////////////////////////////////////////////
    // round-robin grant, only from idle
    ////////////////////////////////////////////////////////////////////////////
    assign grant_wr = (state == ST_IDLE) && wr_req && (!rd_req || !last_wr);
    assign grant_rd = (state == ST_IDLE) && rd_req && !grant_wr;
    assign wr_ready = grant_wr;                        // one-cycle grant pulse
    assign rd_ready = grant_rd;

    // address channels
    assign axi_awvalid = (state == ST_WADDR);
    assign axi_arvalid = (state == ST_RADDR);
    assign axi_awaddr  = cmd_addr;
    assign axi_araddr  = cmd_addr;

    // write data, writer holds word until wr_data_re
    assign axi_wvalid = (state == ST_WDATA);
    assign axi_wdata  = wr_data;
    assign axi_wlast  = axi_wvalid && (beat == WORD_IDX_W'(BURST_WORDS - 1));
    assign wr_data_re = axi_wvalid && axi_wready;
    assign wr_done    = wr_data_re && axi_wlast;

    // read data, always accepted
    assign rd_data_en = (state == ST_RDATA) && axi_rvalid;
    assign rd_data    = axi_rdata;
    assign rd_done    = rd_data_en && axi_rlast;

    always_ff @(posedge ddr_clk)
    begin
        if (grant_wr || grant_rd)
            cmd_addr <= grant_wr ? wr_addr : rd_addr;
    end

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            beat    <= '0;
            last_wr <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (grant_wr)
                    begin
                        state   <= ST_WADDR;
                        last_wr <= 1'b1;
                    end
                    else if (grant_rd)
                    begin
                        state   <= ST_RADDR;
                        last_wr <= 1'b0;
                    end
                end
                ST_WADDR:
                begin
                    if (axi_awready)
                    begin
                        state <= ST_WDATA;             // data after address
                        beat  <= '0;
                    end
                end
                ST_WDATA:
                begin
                    if (wr_data_re)
                    begin
                        beat <= beat + 1'b1;
                        if (axi_wlast)
                            state <= ST_IDLE;
                    end
                end
                ST_RADDR:
                begin
                    if (axi_arready)
                        state <= ST_RDATA;
                end
                ST_RDATA:
                begin
                    if (rd_done)
                        state <= ST_IDLE;              // rlast ends burst
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- frame_buf_top.sv
`timescale 1ns/1ps
module frame_buf_top
    import fb_pkg::*;
(
    input  logic              ddr_clk,
    input  logic              rst_n,
    input  logic              pix_fsync,
    input  logic              pix_valid,
    input  logic [PIX_W-1:0]  pix_data,
    input  logic              rd_fsync,
    input  logic              rd_en,
    output logic              vout_de,
    output logic [PIX_W-1:0]  vout_data,
    output logic              init_done,
    output logic              wr_overflow,
    output logic              rd_underrun,
    input  logic              axi_awready,
    input  logic              axi_wready,
    input  logic              axi_arready,
    input  logic              axi_rvalid,
    input  logic              axi_rlast,
    input  logic [WORD_W-1:0] axi_rdata,
    output logic [ADDR_W-1:0] axi_awaddr,
    output logic [ADDR_W-1:0] axi_araddr,
    output logic              axi_awvalid,
    output logic              axi_wvalid,
    output logic              axi_wlast,
    output logic              axi_arvalid,
    output logic [WORD_W-1:0] axi_wdata
);

    // write command path
    logic              wr_req, wr_ready, wr_done, wr_data_re;
    logic [ADDR_W-1:0] wr_addr;
    logic [WORD_W-1:0] wr_data;
    // read command path
    logic              rd_req, rd_ready, rd_done, rd_data_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;
    // frame handoff writer to reader
    logic              frame_done, done_bank;

    line_writer i_writer (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .pix_fsync   (pix_fsync),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .wr_ready    (wr_ready),
        .wr_done     (wr_done),
        .wr_data_re  (wr_data_re),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_overflow (wr_overflow),
        .frame_done  (frame_done),
        .done_bank   (done_bank)
    );

    line_reader i_reader (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .rd_fsync    (rd_fsync),
        .rd_en       (rd_en),
        .frame_done  (frame_done),
        .done_bank   (done_bank),
        .rd_ready    (rd_ready),
        .rd_done     (rd_done),
        .rd_data_en  (rd_data_en),
        .rd_data     (rd_data),
        .vout_de     (vout_de),
        .vout_data   (vout_data),
        .init_done   (init_done),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_underrun (rd_underrun)
    );

    burst_master i_master (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .axi_awready (axi_awready),
        .axi_wready  (axi_wready),
        .axi_arready (axi_arready),
        .axi_rvalid  (axi_rvalid),
        .axi_rlast   (axi_rlast),
        .axi_rdata   (axi_rdata),
        .wr_ready    (wr_ready),
        .wr_done     (wr_done),
        .wr_data_re  (wr_data_re),
        .rd_ready    (rd_ready),
        .rd_done     (rd_done),
        .rd_data_en  (rd_data_en),
        .rd_data     (rd_data),
        .axi_awaddr  (axi_awaddr),
        .axi_araddr  (axi_araddr),
        .axi_awvalid (axi_awvalid),
        .axi_wvalid  (axi_wvalid),
        .axi_wlast   (axi_wlast),
        .axi_arvalid (axi_arvalid),
        .axi_wdata   (axi_wdata)
    );

endmodule

//--- frame_buf_properties.sv
`timescale 1ns/1ps
module frame_buf_props
    import fb_pkg::*;
(
    input logic              ddr_clk,
    input logic              rst_n,
    input logic              axi_awvalid,
    input logic              axi_awready,
    input logic [ADDR_W-1:0] axi_awaddr,
    input logic              axi_wvalid,
    input logic              axi_wready,
    input logic [WORD_W-1:0] axi_wdata,
    input logic              axi_wlast,
    input logic              axi_arvalid,
    input logic              axi_arready,
    input logic [ADDR_W-1:0] axi_araddr,
    input logic              rd_en,
    input logic              vout_de,
    input logic              init_done,
    input logic              wr_overflow,
    input logic              rd_underrun
);

    int unsigned           fail_cnt = 0;                       // tally of failed assertions
    logic [WORD_IDX_W-1:0] wbeat;                              // wraps after eighth beat

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
            wbeat <= '0;
        else if (axi_wvalid && axi_wready)
            wbeat <= wbeat + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus handshakes
    ////////////////////////////////////////////////////////////////////////////
    aw_hold: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
        else
        begin
            $error("write address dropped or changed before awready");
            fail_cnt++;
        end

    w_hold: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata) && $stable(axi_wlast))
        else
        begin
            $error("write beat dropped or changed before wready");
            fail_cnt++;
        end

    ar_hold: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
        else
        begin
            $error("read address dropped or changed before arready");
            fail_cnt++;
        end

    wlast_pos: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        axi_wvalid |-> (axi_wlast == (wbeat == WORD_IDX_W'(BURST_WORDS - 1))))
        else
        begin
            $error("wlast not on the eighth beat");
            fail_cnt++;
        end

    // video side
    de_delay: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        vout_de == $past(rd_en))
        else
        begin
            $error("vout_de is not rd_en one cycle later");
            fail_cnt++;
        end

    init_sticky: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        init_done |=> init_done)
        else
        begin
            $error("init_done fell");
            fail_cnt++;
        end

    no_flags: assert property (@(posedge ddr_clk) disable iff (!rst_n)
        !wr_overflow && !rd_underrun)
        else
        begin
            $error("overflow or underrun flag set");
            fail_cnt++;
        end

endmodule

//--- tb_frame_buf.sv
`timescale 1ns/1ps
module tb_frame_buf
    import fb_pkg::*;
();

    localparam int IDLE_CYC     = 40;                              // gap after each line
    localparam int READ_LEAD    = 80;                              // prefetch time after rd_fsync
    localparam int NPIX         = H_PIX * V_LINES;
    localparam int PRE_PULSES   = 4;                               // rd_en before any frame
    localparam int FRAME_CYC    = V_LINES * (H_PIX + IDLE_CYC) + READ_LEAD;
    localparam int WATCHDOG_CYC = 3 * FRAME_CYC * 4;
    localparam int MEM_WORDS    = 2 * BANK_BYTES / 8;

    logic              ddr_clk, rst_n;
    logic              pix_fsync, pix_valid, rd_fsync, rd_en;
    logic [PIX_W-1:0]  pix_data;
    logic              vout_de, init_done, wr_overflow, rd_underrun;
    logic [PIX_W-1:0]  vout_data;
    logic              axi_awready, axi_wready, axi_arready, axi_rvalid, axi_rlast;
    logic [WORD_W-1:0] axi_rdata, axi_wdata;
    logic [ADDR_W-1:0] axi_awaddr, axi_araddr;
    logic              axi_awvalid, axi_wvalid, axi_wlast, axi_arvalid;

    logic [WORD_W-1:0] mem [0:MEM_WORDS-1];                        // byte address over 8
    logic [PIX_W-1:0]  frames [2][NPIX];                           // copy of frames A and B
    logic [31:0]       lfsr_state = 32'h5b45;
    int                write_bursts = 0;
    int                mismatch_cnt = 0;
    int                other_cnt = 0;
    int                checked_cnt = 0;
    int                exp_idx = 0;
    int                exp_sel = 0;
    logic              exp_live = 1'b0;                            // frame expected on output
    logic              rd_en_q = 1'b0;
    logic              init_seen = 1'b0;

    frame_buf_top i_dut (.*);

    bind frame_buf_top frame_buf_props i_props (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_awaddr  (axi_awaddr),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_wdata   (axi_wdata),
        .axi_wlast   (axi_wlast),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .rd_en       (rd_en),
        .vout_de     (vout_de),
        .init_done   (init_done),
        .wr_overflow (wr_overflow),
        .rd_underrun (rd_underrun)
    );

    initial
    begin
        ddr_clk = 1'b0;
        forever #2 ddr_clk = ~ddr_clk;                             // 4 ns period
    end

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};                 // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model with random ready stalls and read data gaps
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        int unsigned wptr;
        int unsigned rptr;
        int unsigned rleft;
        logic [31:0] b;
        wptr        = 0;
        rptr        = 0;
        rleft       = 0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_arready = 1'b0;
        axi_rvalid  = 1'b0;
        axi_rlast   = 1'b0;
        axi_rdata   = '0;
        forever
        begin
            @(posedge ddr_clk);
            if (axi_awvalid && axi_awready)
                wptr = int'(axi_awaddr >> 3);
            if (axi_wvalid && axi_wready)
            begin
                mem[wptr] = axi_wdata;
                wptr++;
                if (axi_wlast)
                    write_bursts++;                                // one line stored
            end
            if (axi_rvalid)
            begin
                rptr++;
                rleft--;                                           // master never stalls reads
            end
            if (axi_arvalid && axi_arready)
            begin
                rptr  = int'(axi_araddr >> 3);
                rleft = BURST_WORDS;
            end
            take_bits(4, b);
            @(negedge ddr_clk);
            axi_awready = b[0];
            axi_wready  = b[1];
            axi_arready = b[2];
            axi_rvalid  = (rleft != 0) && b[3];                    // gaps in read data
            axi_rdata   = (rleft != 0) ? mem[rptr] : '0;
            axi_rlast   = (rleft == 1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor on the rising edge
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge ddr_clk)
    begin
        logic [PIX_W-1:0] exp;
        if (rst_n)
        begin
            assert (vout_de === rd_en_q)
            else
            begin
                $display("mismatch vout_de exp %h got %h", rd_en_q, vout_de);
                mismatch_cnt++;
            end
            if (init_seen && !init_done)
            begin
                $display("init_done fell after it had been set");
                other_cnt++;
            end
            if (init_done && !init_seen && write_bursts != V_LINES)
            begin
                $display("init_done rose before frame A was fully stored");
                other_cnt++;
            end
            if (init_done)
                init_seen = 1'b1;
            if (vout_de)
            begin
                exp = (exp_live && exp_idx < NPIX) ? frames[exp_sel][exp_idx] : '0;
                assert (vout_data === exp)
                else
                begin
                    $display("mismatch vout_data exp %h got %h", exp, vout_data);
                    mismatch_cnt++;
                end
                exp_idx++;
                checked_cnt++;
            end
            if (rd_fsync)
                exp_idx = 0;                                       // raster restarts
        end
        rd_en_q = rd_en;
    end

    task automatic check_reset_outputs();
        assert (!axi_awvalid && !axi_wvalid && !axi_arvalid && !i_dut.wr_req
                && !i_dut.rd_req && !vout_de && !init_done && !wr_overflow && !rd_underrun)
        else
        begin
            $display("an output was not low after reset");
            other_cnt++;
        end
    endtask

    task automatic write_frame(input int f);
        logic [31:0] v;
        for (int line = 0; line < V_LINES; line++)
        begin
            for (int px = 0; px < H_PIX; px++)
            begin
                @(negedge ddr_clk);
                take_bits(PIX_W, v);
                pix_valid = 1'b1;
                pix_fsync = (line == 0) && (px == 0);              // first pixel of frame
                pix_data  = v[PIX_W-1:0];
                frames[f][line*H_PIX+px] = v[PIX_W-1:0];
            end
            @(negedge ddr_clk);
            pix_valid = 1'b0;
            pix_fsync = 1'b0;
            repeat (IDLE_CYC - 1) @(negedge ddr_clk);
        end
    endtask

    task automatic read_frame(input int f);
        @(negedge ddr_clk);
        rd_fsync = 1'b1;
        exp_sel  = f;
        exp_live = 1'b1;
        @(negedge ddr_clk);
        rd_fsync = 1'b0;
        repeat (READ_LEAD) @(negedge ddr_clk);
        for (int line = 0; line < V_LINES; line++)
        begin
            repeat (H_PIX)
            begin
                @(negedge ddr_clk);
                rd_en = 1'b1;
            end
            @(negedge ddr_clk);
            rd_en = 1'b0;
            repeat (IDLE_CYC - 1) @(negedge ddr_clk);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_cnt, other_cnt, i_dut.i_props.fail_cnt);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge ddr_clk);
        $display("watchdog expired before the test sequence finished");
        print_counts();
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        rst_n     = 1'b0;
        pix_fsync = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        rd_fsync  = 1'b0;
        rd_en     = 1'b0;
        repeat (2) @(negedge ddr_clk);
        rst_n = 1'b1;
        @(negedge ddr_clk);
        check_reset_outputs();
        repeat (PRE_PULSES)                                        // zeros expected before any frame
        begin
            @(negedge ddr_clk);
            rd_en = 1'b1;
            @(negedge ddr_clk);
            rd_en = 1'b0;
        end
        write_frame(0);                                            // frame A into bank 0
        while (!init_done)
            @(negedge ddr_clk);
        read_frame(0);
        fork
            write_frame(1);                                        // frame B into bank 1
            begin
                repeat (100) @(negedge ddr_clk);
                read_frame(0);                                     // still shows A
            end
        join
        while (write_bursts < 2 * V_LINES)
            @(negedge ddr_clk);
        repeat (4) @(negedge ddr_clk);
        read_frame(1);
        repeat (10) @(negedge ddr_clk);
        if (checked_cnt != PRE_PULSES + 3 * NPIX)
        begin
            $display("wrong number of output pixels, %0d seen", checked_cnt);
            other_cnt++;
        end
        print_counts();
        if (mismatch_cnt + other_cnt + i_dut.i_props.fail_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- files.f
fb_pkg.sv
line_writer.sv
line_reader.sv
burst_master.sv
frame_buf_top.sv
frame_buf_properties.sv
tb_frame_buf.sv

//--- Makefile
# Verilator flow for the frame buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_buf
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
